//--- common/load_settings.svh
// Load path sizes. LQ_SIZE and MEM_CREDITS must be at least 1, MEM_WORDS a power of two.
`ifndef LOAD_SETTINGS_SVH
`define LOAD_SETTINGS_SVH

// ##################################################
// Load queue
// ##################################################
// Pending load slots.
`define LQ_SIZE 4
// Width of the load id.
`define ID_BITS 4

// Data and address width.
`define XLEN 32

// ##################################################
// Data RAM
// ##################################################
`define MEM_WORDS 64
// Request buffer depth, also the initial credit count.
`define MEM_CREDITS 2

`endif

//--- common/load_pkg.sv
// Types of the load side. Byte, halfword and word accesses only, always naturally aligned.
`include "load_settings.svh"

package load_pkg;

    // Register index of the integer file.
    typedef logic [4:0] ridx_t;

    // Access size.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } load_size_e;

    // ##################################################
    // Queue entry and writeback
    // ##################################################
    typedef struct packed {
        logic [`ID_BITS-1:0] id;
        ridx_t               rd_idx;
        logic [`XLEN-1:0]    addr;        // Byte address.
        load_size_e          size;
        logic                is_unsigned; // Zero-extend when set.
    } load_entry_t;

    typedef struct packed {
        logic [`ID_BITS-1:0] id;
        ridx_t               rd_idx;
        logic [`XLEN-1:0]    data;        // Already extended.
    } wb_t;

endpackage

//--- common/mem_pkg.sv
// Types of the data RAM side. The whole queue entry rides along as the request tag.
`include "load_settings.svh"

package mem_pkg;

    import load_pkg::*;

    // Word index into the RAM array.
    localparam int MEM_ABITS   = $clog2(`MEM_WORDS);
    // Enough bits to hold MEM_CREDITS itself.
    localparam int CREDIT_BITS = $clog2(`MEM_CREDITS + 1);

    typedef logic [MEM_ABITS-1:0] mem_index_t;

    // ##################################################
    // Read request and response
    // ##################################################
    typedef struct packed {
        logic [`XLEN-3:0] word_addr; // Byte address without the low two bits.
        load_entry_t      tag;
    } mem_req_t;

    typedef struct packed {
        logic [`XLEN-1:0] rdata;
        load_entry_t      tag;       // Same tag as the request.
    } mem_rsp_t;

endpackage

//--- load_unit/load_queue.sv
// In-order load queue. Only slot 0 may leave, and no push is taken while the last slot is full.
`timescale 1ns/1ps
`include "load_settings.svh"

module load_queue (
    input  var logic                          clk,
    input  var logic                          reset,

    // Decoded loads.
    input  var load_pkg::load_entry_t         s_entry,
    input  var logic                          s_valid,
    output var logic                          s_ready,

    // Head towards the issue stage.
    output var load_pkg::load_entry_t         head,
    output var logic                          head_valid,
    input  var logic                          head_pop,

    // Hazard check.
    output var logic [`LQ_SIZE-1:0]           pending_valid,
    output var load_pkg::ridx_t [`LQ_SIZE-1:0] pending_rd
);

    import load_pkg::*;

    load_entry_t [`LQ_SIZE-1:0] que_entry;
    logic        [`LQ_SIZE-1:0] que_valid;

    load_entry_t [`LQ_SIZE-1:0] next_entry;
    logic        [`LQ_SIZE-1:0] next_valid;

    // ##################################################
    // Next queue contents
    // ##################################################
    always_comb begin : next_calc
        logic placed;

        next_entry = que_entry;
        next_valid = que_valid;
        placed     = 1'b0;

        // Everything moves one slot toward the head.
        if (head_pop) begin
            for (int i = 0; i < `LQ_SIZE - 1; i++) begin
                next_entry[i] = que_entry[i+1];
                next_valid[i] = que_valid[i+1];
            end
            next_valid[`LQ_SIZE-1] = 1'b0;
        end

        // Lowest free slot after the shift.
        if (s_valid && s_ready) begin
            for (int i = 0; i < `LQ_SIZE; i++) begin
                if (!next_valid[i] && !placed) begin
                    next_entry[i] = s_entry;
                    next_valid[i] = 1'b1;
                    placed        = 1'b1;
                end
            end
        end
    end

    // ##################################################
    // Slot registers
    // ##################################################
    always_ff @(posedge clk) begin
        if (reset) begin
            que_valid <= '0;
        end else begin
            que_valid <= next_valid;
        end
    end

    always_ff @(posedge clk) begin
        que_entry <= next_entry; // Payload only.
    end

    assign s_ready    = !que_valid[`LQ_SIZE-1];

    assign head       = que_entry[0];
    assign head_valid = que_valid[0];

    // Destinations of every waiting load, oldest in slot 0.
    assign pending_valid = que_valid;

    always_comb begin
        for (int i = 0; i < `LQ_SIZE; i++) begin
            pending_rd[i] = que_entry[i].rd_idx;
        end
    end

endmodule

//--- load_unit/load_issue.sv
// Issue stage. The RAM must return exactly one credit per request it takes out of its buffer.
`timescale 1ns/1ps
`include "load_settings.svh"

module load_issue (
    input  var logic                  clk,
    input  var logic                  reset,

    // Queue head.
    input  var load_pkg::load_entry_t head,
    input  var logic                  head_valid,
    output var logic                  head_pop,

    // Requests to the data RAM.
    output var mem_pkg::mem_req_t     req,
    output var logic                  req_valid,
    input  var logic                  credit_return
);

    import mem_pkg::*;

    // Free slots in the RAM request buffer.
    logic [CREDIT_BITS-1:0] credits;

    // ##################################################
    // Pop and credit counter
    // ##################################################
    // Pop whenever a credit is left.
    assign head_pop = head_valid && (credits != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            credits   <= CREDIT_BITS'(`MEM_CREDITS);
            req_valid <= 1'b0;
        end else begin
            req_valid <= head_pop;

            // Spend and return in one cycle cancel out.
            case ({head_pop, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // ##################################################
    // Request register
    // ##################################################
    always_ff @(posedge clk) begin
        if (head_pop) begin
            req.word_addr <= head.addr[`XLEN-1:2];
            req.tag       <= head; // Travels with the read.
        end
    end

endmodule

//--- load_unit/load_align.sv
// Alignment and extension of returned words. Assumes the address is naturally aligned.
`timescale 1ns/1ps
`include "load_settings.svh"

module load_align (
    input  var logic              clk,
    input  var logic              reset,

    // RAM responses.
    input  var mem_pkg::mem_rsp_t rsp,
    input  var logic              rsp_valid,

    // Register writeback.
    output var load_pkg::wb_t     wb,
    output var logic              wb_valid
);

    import load_pkg::*;

    logic [1:0]       offset;
    logic [7:0]       sel_byte;
    logic [15:0]      sel_half;
    logic [`XLEN-1:0] ext_data;

    // ##################################################
    // Select and extend
    // ##################################################
    always_comb begin
        offset   = rsp.tag.addr[1:0];
        sel_byte = rsp.rdata[8*offset +: 8];
        sel_half = rsp.rdata[16*offset[1] +: 16]; // Bit 0 is zero for halves.

        case (rsp.tag.size)
            SIZE_BYTE: ext_data = {{(`XLEN-8){sel_byte[7] && !rsp.tag.is_unsigned}}, sel_byte};
            SIZE_HALF: ext_data = {{(`XLEN-16){sel_half[15] && !rsp.tag.is_unsigned}}, sel_half};
            default:   ext_data = rsp.rdata;
        endcase
    end

    // ##################################################
    // Writeback register
    // ##################################################
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= rsp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            wb.id     <= rsp.tag.id;
            wb.rd_idx <= rsp.tag.rd_idx;
            wb.data   <= ext_data;
        end
    end

endmodule

//--- hw/data_ram.sv
// Word RAM behind a MEM_CREDITS deep request buffer. Requests beyond the credits are not checked.
`timescale 1ns/1ps
`include "load_settings.svh"

module data_ram (
    input  var logic                clk,
    input  var logic                reset,
    input  var mem_pkg::mem_req_t   req,
    input  var logic                req_valid,
    output var logic                credit_return,
    input  var logic                mem_stall,
    input  var logic                mem_wr_en,
    input  var mem_pkg::mem_index_t mem_wr_addr,
    input  var logic [`XLEN-1:0]    mem_wr_data,
    output var mem_pkg::mem_rsp_t   rsp,
    output var logic                rsp_valid
);

    import load_pkg::*;
    import mem_pkg::*;

    localparam int PTR_BITS = (`MEM_CREDITS > 1) ? $clog2(`MEM_CREDITS) : 1;

    logic [`XLEN-1:0]       mem_array [`MEM_WORDS];
    mem_req_t               buf_req   [`MEM_CREDITS];
    logic [PTR_BITS-1:0]    wr_ptr;
    logic [PTR_BITS-1:0]    rd_ptr;
    logic [CREDIT_BITS-1:0] buf_count;
    logic                   rd_en;
    logic                   rd_valid;
    logic [`XLEN-1:0]       rd_data;
    load_entry_t            rd_tag;

    // One read per unstalled cycle, the credit goes back at once.
    assign rd_en         = (buf_count != '0) && !mem_stall;
    assign credit_return = rd_en;

    // ##################################################
    // Request buffer control
    // ##################################################
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            buf_count <= '0;
            rd_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(`MEM_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(`MEM_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            buf_count <= buf_count + CREDIT_BITS'(req_valid) - CREDIT_BITS'(rd_en);
            rd_valid  <= rd_en;
            rsp_valid <= rd_valid;
        end
    end

    // ##################################################
    // Storage and read pipeline
    // ##################################################
    always_ff @(posedge clk) begin
        if (req_valid) buf_req[wr_ptr] <= req;
        if (mem_wr_en) mem_array[mem_wr_addr] <= mem_wr_data; // Preload port.
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem_array[buf_req[rd_ptr].word_addr[MEM_ABITS-1:0]];
            rd_tag  <= buf_req[rd_ptr].tag;
        end
        if (rd_valid) begin
            rsp.rdata <= rd_data;
            rsp.tag   <= rd_tag;
        end
    end

endmodule

//--- hw/load_subsystem_top.sv
// Load path top. Writeback has no back-pressure, and results leave in acceptance order.
`timescale 1ns/1ps
`include "load_settings.svh"

module load_subsystem_top (
    input  var logic                           clk,
    input  var logic                           reset,

    // Decoded loads.
    input  var load_pkg::load_entry_t          s_entry,
    input  var logic                           s_valid,
    output var logic                           s_ready,

    // Register writeback.
    output var load_pkg::wb_t                  wb,
    output var logic                           wb_valid,

    // Hazard check.
    output var logic [`LQ_SIZE-1:0]            pending_valid,
    output var load_pkg::ridx_t [`LQ_SIZE-1:0] pending_rd,

    // RAM stall and preload.
    input  var logic                           mem_stall,
    input  var logic                           mem_wr_en,
    input  var mem_pkg::mem_index_t            mem_wr_addr,
    input  var logic [`XLEN-1:0]               mem_wr_data
);

    import load_pkg::*;
    import mem_pkg::*;

    load_entry_t head;
    logic        head_valid;
    logic        head_pop;
    mem_req_t    req;
    logic        req_valid;
    logic        credit_return;
    mem_rsp_t    rsp;
    logic        rsp_valid;

    // ##################################################
    // Queue and issue
    // ##################################################
    load_queue queue_i (
        .clk           (clk),
        .reset         (reset),
        .s_entry       (s_entry),
        .s_valid       (s_valid),
        .s_ready       (s_ready),
        .head          (head),
        .head_valid    (head_valid),
        .head_pop      (head_pop),
        .pending_valid (pending_valid),
        .pending_rd    (pending_rd)
    );

    load_issue issue_i (
        .clk           (clk),
        .reset         (reset),
        .head          (head),
        .head_valid    (head_valid),
        .head_pop      (head_pop),
        .req           (req),
        .req_valid     (req_valid),
        .credit_return (credit_return)
    );

    // ##################################################
    // Memory and alignment
    // ##################################################
    data_ram ram_i (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .req_valid     (req_valid),
        .credit_return (credit_return),
        .mem_stall     (mem_stall),
        .mem_wr_en     (mem_wr_en),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_data   (mem_wr_data),
        .rsp           (rsp),
        .rsp_valid     (rsp_valid)
    );

    load_align align_i (
        .clk           (clk),
        .reset         (reset),
        .rsp           (rsp),
        .rsp_valid     (rsp_valid),
        .wb            (wb),
        .wb_valid      (wb_valid)
    );

endmodule

//--- tests/load_subsystem_checker.sv
// Load path checker, bound into load_subsystem_top. Expects the RAM preloaded before loads arrive.
`timescale 1ns/1ps
`include "load_settings.svh"

module load_subsystem_checker (
    input var logic                           clk,
    input var logic                           reset,
    input var load_pkg::load_entry_t          s_entry,
    input var logic                           s_valid,
    input var logic                           s_ready,
    input var logic                           head_pop,
    input var load_pkg::wb_t                  wb,
    input var logic                           wb_valid,
    input var logic [`LQ_SIZE-1:0]            pending_valid,
    input var load_pkg::ridx_t [`LQ_SIZE-1:0] pending_rd,
    input var logic                           mem_stall,
    input var logic                           mem_wr_en,
    input var mem_pkg::mem_index_t            mem_wr_addr,
    input var logic [`XLEN-1:0]               mem_wr_data
);

    import load_pkg::*;
    import mem_pkg::*;

    localparam int RING = 16; // Well above the loads in flight.

    int               error_count = 0;
    logic [`XLEN-1:0] ref_mem [`MEM_WORDS];
    wb_t              exp_q [RING];
    ridx_t            pend_q [RING];
    int               exp_rd, exp_wr, exp_cnt;
    int               pend_rd, pend_wr, pend_cnt;
    logic             accept;
    logic             pend_ok;

    assign accept = s_valid && s_ready;

    // Picks the addressed bytes by shifting, then fills the upper bits.
    function automatic wb_t expect_wb(input load_entry_t e, input logic [`XLEN-1:0] w);
        logic [`XLEN-1:0] v;
        wb_t              r;
        v = w >> (8 * e.addr[1:0]);
        case (e.size)
            SIZE_BYTE: begin
                v = v & 32'h0000_00ff;
                if (!e.is_unsigned && v[7]) v = v | 32'hffff_ff00;
            end
            SIZE_HALF: begin
                v = v & 32'h0000_ffff;
                if (!e.is_unsigned && v[15]) v = v | 32'hffff_0000;
            end
            default: v = w;
        endcase
        r.id     = e.id;
        r.rd_idx = e.rd_idx;
        r.data   = v;
        return r;
    endfunction

    // ##################################################
    // Reference model
    // ##################################################
    always_ff @(posedge clk) begin
        if (mem_wr_en) ref_mem[mem_wr_addr] <= mem_wr_data;
        if (reset) begin
            exp_rd   <= 0;
            exp_wr   <= 0;
            exp_cnt  <= 0;
            pend_rd  <= 0;
            pend_wr  <= 0;
            pend_cnt <= 0;
        end else begin
            if (accept) begin
                exp_q[exp_wr]   <= expect_wb(s_entry, ref_mem[s_entry.addr[MEM_ABITS+1:2]]);
                pend_q[pend_wr] <= s_entry.rd_idx;
                exp_wr          <= (exp_wr + 1) % RING;
                pend_wr         <= (pend_wr + 1) % RING;
            end
            if (wb_valid) exp_rd <= (exp_rd + 1) % RING;
            if (head_pop) pend_rd <= (pend_rd + 1) % RING;
            exp_cnt  <= exp_cnt + int'(accept) - int'(wb_valid);
            pend_cnt <= pend_cnt + int'(accept) - int'(head_pop);
        end
    end

    // Slot i must hold the i-th oldest unpopped load.
    always_comb begin
        pend_ok = 1'b1;
        for (int i = 0; i < `LQ_SIZE; i++) begin
            if (pending_valid[i] != (i < pend_cnt)) pend_ok = 1'b0;
            else if (pending_valid[i] && pending_rd[i] != pend_q[(pend_rd + i) % RING])
                pend_ok = 1'b0;
        end
    end

    // ##################################################
    // Assertions
    // ##################################################
    a_reset_idle: assert property (@(posedge clk)
        reset |=> !wb_valid && pending_valid == '0 && s_ready)
        else begin error_count++; $error("[FAIL] %0t: outputs not idle after reset", $time); end

    a_wb_value: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> exp_cnt > 0 && wb == exp_q[exp_rd])
        else begin error_count++; $error("[FAIL] %0t: unexpected writeback", $time); end

    a_ready_full: assert property (@(posedge clk) disable iff (reset)
        s_ready == ($countones(pending_valid) < `LQ_SIZE))
        else begin error_count++; $error("[FAIL] %0t: s_ready vs queue fill", $time); end

    a_pending: assert property (@(posedge clk) disable iff (reset) pend_ok)
        else begin error_count++; $error("[FAIL] %0t: pending destinations wrong", $time); end

    // Read happens three edges after acceptance when not stalled.
    a_latency: assert property (@(posedge clk) disable iff (reset)
        (accept && exp_cnt == 0) ##3 !mem_stall |-> ##2 !wb_valid ##1 wb_valid)
        else begin error_count++; $error("[FAIL] %0t: load latency not 5", $time); end

endmodule

//--- tests/load_subsystem_tb.sv
// Load path testbench. All value checks sit in the bound checker; this drives and waits.
`timescale 1ns/1ps
`include "load_settings.svh"

module load_subsystem_tb;

    import load_pkg::*;
    import mem_pkg::*;

    localparam int N_SINGLE = 8;
    localparam int N_MIXED  = 60;
    localparam int N_BURST  = 40;
    localparam int N_LOADS  = N_SINGLE + N_MIXED + N_BURST;
    localparam logic [31:0] SEED = 32'd23;

    logic                           clk;
    logic                           reset;
    load_entry_t                    s_entry;
    logic                           s_valid, s_ready;
    wb_t                            wb;
    logic                           wb_valid;
    logic [`LQ_SIZE-1:0]            pending_valid;
    ridx_t [`LQ_SIZE-1:0]           pending_rd;
    logic                           mem_stall, mem_wr_en;
    mem_index_t                     mem_wr_addr;
    logic [`XLEN-1:0]               mem_wr_data;

    int          sent_count = 0;
    int          wb_count = 0;
    int          stall_mode = 0; // 0 off, 1 light, 2 heavy.
    logic [31:0] rng_load, rng_stall;

    load_subsystem_top dut_i (
        .clk(clk), .reset(reset),
        .s_entry(s_entry), .s_valid(s_valid), .s_ready(s_ready),
        .wb(wb), .wb_valid(wb_valid),
        .pending_valid(pending_valid), .pending_rd(pending_rd),
        .mem_stall(mem_stall), .mem_wr_en(mem_wr_en),
        .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data)
    );

    bind load_subsystem_top load_subsystem_checker chk_i (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_drive();
        @(posedge clk);
        #1;
    endtask

    // Random aligned load anywhere in the RAM.
    task automatic make_entry(output load_entry_t e);
        logic [31:0] r;
        logic [1:0]  off;
        rng_load = xorshift32(rng_load);
        r        = rng_load;
        case (r[11:10])
            2'd1: begin
                e.size = SIZE_HALF;
                off    = {r[18], 1'b0};
            end
            2'd2: begin
                e.size = SIZE_WORD;
                off    = 2'd0;
            end
            default: begin
                e.size = SIZE_BYTE;
                off    = r[19:18];
            end
        endcase
        e.id          = r[3:0];
        e.rd_idx      = r[8:4];
        e.is_unsigned = r[9];
        e.addr        = `XLEN'({r[17:12], off});
    endtask

    // Leaves s_valid high so loads go back to back.
    task automatic send_load();
        load_entry_t e;
        make_entry(e);
        s_entry = e;
        s_valid = 1'b1;
        while (!s_ready) next_drive();
        next_drive();
        sent_count++;
    endtask

    task automatic wait_drain();
        s_valid = 1'b0;
        while (wb_count != sent_count) next_drive();
        next_drive();
    endtask

    always @(negedge clk) begin
        if (!reset && wb_valid) wb_count++;
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ##################################################
    // Stall bursts
    // ##################################################
    initial begin : stall_gen
        int len;
        forever begin
            next_drive();
            if (stall_mode != 0) begin
                rng_stall = xorshift32(rng_stall);
                len       = 1 + rng_stall % (stall_mode == 2 ? 10 : 3);
                mem_stall = 1'b1;
                repeat (len) next_drive();
                rng_stall = xorshift32(rng_stall);
                len       = 1 + rng_stall % (stall_mode == 2 ? 2 : 4);
            end else begin
                len = 1;
            end
            mem_stall = 1'b0;
            repeat (len - 1) next_drive();
        end
    end

    initial begin : watchdog
        repeat (N_LOADS * 20 + 200) @(posedge clk);
        $display("Timeout: the run did not finish, %0d of %0d writebacks seen.",
                 wb_count, sent_count);
        $display("Something failed");
        $finish;
    end

    // ##################################################
    // Main sequence
    // ##################################################
    initial begin
        reset       = 1'b1;
        s_entry     = '0;
        s_valid     = 1'b0;
        mem_stall   = 1'b0;
        mem_wr_en   = 1'b0;
        mem_wr_addr = '0;
        mem_wr_data = '0;
        rng_load    = SEED;
        rng_stall   = xorshift32(SEED); // Same seed one step ahead.
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;

        for (int i = 0; i < `MEM_WORDS; i++) begin
            rng_load    = xorshift32(rng_load);
            mem_wr_en   = 1'b1;
            mem_wr_addr = mem_index_t'(i);
            mem_wr_data = rng_load;
            next_drive();
        end
        mem_wr_en = 1'b0;
        next_drive();

        repeat (N_SINGLE) begin // Isolated loads at minimum latency.
            send_load();
            wait_drain();
        end

        stall_mode <= 1;
        repeat (N_MIXED) begin
            send_load();
            if (rng_load[21:20] == 2'd0) begin
                s_valid = 1'b0;
                next_drive();
            end
        end
        wait_drain();

        stall_mode <= 2; // Fills the queue.
        repeat (N_BURST) send_load();
        wait_drain();
        stall_mode <= 0;
        repeat (5) next_drive();

        $display("Run done: %0d loads, %0d writebacks, %0d errors.",
                 sent_count, wb_count, dut_i.chk_i.error_count);
        if (dut_i.chk_i.error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+common
common/load_pkg.sv
common/mem_pkg.sv
load_unit/load_queue.sv
load_unit/load_issue.sv
load_unit/load_align.sv
hw/data_ram.sv
hw/load_subsystem_top.sv
tests/load_subsystem_checker.sv
tests/load_subsystem_tb.sv
